// ==== design/isaPkg.sv ====
package isaPkg;

    // major opcodes of the three supported formats
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // register-register arithmetic
        OPIMM  = 7'b0010011,  // register-immediate arithmetic
        BRANCH = 7'b1100011
    } opcodeT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm12;   // sign bit is imm12[11]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    // the branch offset is scattered over the word, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    // one instruction word seen through each format
    typedef union packed {
        logic [31:0] raw;
        rTypeT       r;
        iTypeT       i;
        bTypeT       b;
    } instWordT;

    localparam logic [2:0] f3Add = 3'b000;
    localparam logic [2:0] f3And = 3'b111;
    localparam logic [2:0] f3Or  = 3'b110;

    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    localparam logic [6:0] funct7Sub = 7'b0100000;  // with f3Add turns ADD into SUB

endpackage

// ==== design/execPkg.sv ====
package execPkg;

    // width of the data fields in the records below
    localparam int defaultWidth = 64;

    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluSub = 2'b01,
        aluAnd = 2'b10,
        aluOr  = 2'b11
    } aluOpT;

    // one decoded instruction on its way into the ALU
    typedef struct packed {
        logic                    valid;
        aluOpT                   aluOp;
        logic                    isBranch;
        logic                    writesRd;
        logic [4:0]              rd;
        logic [2:0]              funct3;
        logic [defaultWidth-1:0] opA;
        logic [defaultWidth-1:0] opB;
        logic [defaultWidth-1:0] branchOff;  // already sign-extended
    } decodedT;

    // comparison results of opA - opB
    typedef struct packed {
        logic equal;
        logic lessSigned;
        logic lessUnsigned;
    } aluFlagsT;

    // result write, also what the decoder forwards from
    typedef struct packed {
        logic                    valid;
        logic [4:0]              rd;
        logic [defaultWidth-1:0] data;
    } wbT;

endpackage

// ==== design/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder #(
    parameter int dataWidth = 64
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instValid,
    input  isaPkg::instWordT       inst,
    input  logic [dataWidth-1:0]   rdData1,
    input  logic [dataWidth-1:0]   rdData2,
    input  execPkg::wbT            fwd,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    output execPkg::decodedT       dec,
    output logic                   illegal
);
    import isaPkg::*;
    import execPkg::*;

    logic                 legal;
    aluOpT                aluOp;
    logic                 isBranch;
    logic                 writesRd;
    logic [dataWidth-1:0] src1;
    logic [dataWidth-1:0] src2;
    logic [dataWidth-1:0] immI;
    logic [dataWidth-1:0] immB;
    decodedT              decNext;

    // source fields sit at the same bits in every format
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;

    assign immI = {{(dataWidth-12){inst.i.imm12[11]}}, inst.i.imm12};
    assign immB = {{(dataWidth-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                   inst.b.imm10to5, inst.b.imm4to1, 1'b0};

    // the result the ALU registers this cycle wins over the file contents
    assign src1 = (fwd.valid && fwd.rd == rs1 && rs1 != 5'd0) ? fwd.data[dataWidth-1:0] : rdData1;
    assign src2 = (fwd.valid && fwd.rd == rs2 && rs2 != 5'd0) ? fwd.data[dataWidth-1:0] : rdData2;

    always_comb begin
        legal    = 1'b0;
        aluOp    = aluAdd;
        isBranch = 1'b0;
        writesRd = 1'b0;
        case (inst.r.opcode)
            OP: begin
                writesRd = 1'b1;
                case (inst.r.funct3)
                    f3Add: begin
                        legal = inst.r.funct7 == 7'd0 || inst.r.funct7 == funct7Sub;
                        aluOp = (inst.r.funct7 == funct7Sub) ? aluSub : aluAdd;
                    end
                    f3And: begin
                        legal = inst.r.funct7 == 7'd0;
                        aluOp = aluAnd;
                    end
                    f3Or: begin
                        legal = inst.r.funct7 == 7'd0;
                        aluOp = aluOr;
                    end
                    default: legal = 1'b0;
                endcase
            end
            OPIMM: begin
                writesRd = 1'b1;
                legal    = inst.i.funct3 inside {f3Add, f3And, f3Or};
                aluOp    = (inst.i.funct3 == f3And) ? aluAnd :
                           (inst.i.funct3 == f3Or)  ? aluOr  : aluAdd;
            end
            BRANCH: begin
                isBranch = 1'b1;
                aluOp    = aluSub;  // flags come out of the difference
                legal    = inst.b.funct3 inside {f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        decNext.valid     = instValid && legal;
        decNext.aluOp     = aluOp;
        decNext.isBranch  = isBranch;
        decNext.writesRd  = writesRd;
        decNext.rd        = inst.r.rd;
        decNext.funct3    = inst.r.funct3;
        decNext.opA       = defaultWidth'(src1);
        decNext.opB       = defaultWidth'((inst.r.opcode == OPIMM) ? immI : src2);
        decNext.branchOff = defaultWidth'(immB);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dec.valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            dec     <= decNext;
            illegal <= instValid && !legal;
        end
    end

    // forwarding relies on fwd being the record of the instruction decoded last cycle
    assert property (@(posedge clk) disable iff (!rstN)
        fwd.valid |-> dec.valid && dec.writesRd && fwd.rd == dec.rd);

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
    parameter int dataWidth = 64
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  execPkg::wbT          wr,
    output logic [dataWidth-1:0] rdData1,
    output logic [dataWidth-1:0] rdData2
);
    logic [dataWidth-1:0] regs [1:31];  // x0 has no storage

    // a write landing this cycle is seen by the read in the same cycle
    function automatic logic [dataWidth-1:0] readReg(input logic [4:0] addr);
        logic [dataWidth-1:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wr.valid && wr.rd == addr) begin
            value = wr.data[dataWidth-1:0];
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rdData1 = readReg(rs1);
        rdData2 = readReg(rs2);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.rd != 5'd0) begin  // writes to x0 are dropped
            regs[wr.rd] <= wr.data[dataWidth-1:0];
        end
    end

    // a stored write reads back on the next cycle unless a newer write to it lands
    assert property (@(posedge clk) disable iff (!rstN)
        $past(wr.valid && wr.rd != 5'd0) && rs1 == $past(wr.rd) && !(wr.valid && wr.rd == rs1)
        |-> rdData1 == $past(wr.data[dataWidth-1:0]));

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int dataWidth = 64
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  execPkg::decodedT     dec,
    output execPkg::wbT          wb,
    output execPkg::wbT          fwd,       // the write being registered this cycle
    output execPkg::aluFlagsT    flags,
    output logic                 brValid,
    output logic [2:0]           brFunct3,
    output logic [dataWidth-1:0] brOff
);
    import execPkg::*;

    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    logic [dataWidth-1:0] bEff;
    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] result;
    logic                 isSub;
    logic                 carryOut;
    logic                 overflow;
    aluFlagsT             flagsNext;

    assign a     = dec.opA[dataWidth-1:0];
    assign b     = dec.opB[dataWidth-1:0];
    assign isSub = dec.aluOp == aluSub;

    // one adder does both, subtraction is a + ~b + 1
    assign bEff = isSub ? ~b : b;
    assign {carryOut, sum} = {1'b0, a} + {1'b0, bEff} + {{dataWidth{1'b0}}, isSub};

    // a - b overflows when the signs differ and the result takes the sign of b
    assign overflow = (a[dataWidth-1] ^ b[dataWidth-1]) & (sum[dataWidth-1] ^ a[dataWidth-1]);

    assign flagsNext.equal        = ~|sum;
    assign flagsNext.lessSigned   = sum[dataWidth-1] ^ overflow;
    assign flagsNext.lessUnsigned = ~carryOut;  // no carry out means a borrow

    always_comb begin
        case (dec.aluOp)
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            default: result = sum;
        endcase
    end

    assign fwd.valid = dec.valid && dec.writesRd;
    assign fwd.rd    = dec.rd;
    assign fwd.data  = defaultWidth'(result);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb.valid <= 1'b0;
            brValid  <= 1'b0;
        end else begin
            wb      <= fwd;
            brValid <= dec.valid && dec.isBranch;
            if (dec.valid && dec.isBranch) begin
                brFunct3 <= dec.funct3;
                brOff    <= dec.branchOff[dataWidth-1:0];
                flags    <= flagsNext;
            end
        end
    end

    // a branch never writes back
    assert property (@(posedge clk) disable iff (!rstN) !(wb.valid && brValid));

endmodule

// ==== design/branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit #(
    parameter int dataWidth = 64
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 advance,   // a non-branch instruction finished
    input  logic                 brValid,
    input  logic [2:0]           brFunct3,
    input  logic [dataWidth-1:0] brOff,
    input  execPkg::aluFlagsT    flags,
    output logic                 branchValid,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] pc
);
    import isaPkg::*;

    logic                 cond;
    logic [dataWidth-1:0] pcReg;

    always_comb begin
        case (brFunct3)
            f3Beq:   cond = flags.equal;
            f3Bne:   cond = !flags.equal;
            f3Blt:   cond = flags.lessSigned;
            f3Bge:   cond = !flags.lessSigned;
            f3Bltu:  cond = flags.lessUnsigned;
            f3Bgeu:  cond = !flags.lessUnsigned;
            default: cond = 1'b0;  // decoder rejects the other codes
        endcase
    end

    assign branchValid = brValid;
    assign branchTaken = brValid && cond;

    // pc shows the value after the instruction that completes this cycle,
    // so it moves together with branchValid
    assign pc = (advance || brValid) ? pcReg + (branchTaken ? brOff : dataWidth'(4)) : pcReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcReg <= '0;
        end else begin
            pcReg <= pc;
        end
    end

endmodule

// ==== design/execCore.sv ====
`timescale 1ns/1ps

module execCore #(
    parameter int dataWidth = 64
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instValid,
    input  isaPkg::instWordT     inst,
    output execPkg::wbT          wb,
    output logic                 branchValid,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] pc,
    output logic                 illegal
);
    import execPkg::*;

    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [dataWidth-1:0] rdData1;
    logic [dataWidth-1:0] rdData2;
    decodedT              dec;
    wbT                   fwd;
    aluFlagsT             flags;
    logic                 brValid;
    logic [2:0]           brFunct3;
    logic [dataWidth-1:0] brOff;

    instDecoder #(.dataWidth(dataWidth)) i_instDecoder (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .inst      (inst),
        .rdData1   (rdData1),
        .rdData2   (rdData2),
        .fwd       (fwd),
        .rs1       (rs1),
        .rs2       (rs2),
        .dec       (dec),
        .illegal   (illegal)
    );

    regFile #(.dataWidth(dataWidth)) i_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .wr      (wb),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    alu #(.dataWidth(dataWidth)) i_alu (
        .clk      (clk),
        .rstN     (rstN),
        .dec      (dec),
        .wb       (wb),
        .fwd      (fwd),
        .flags    (flags),
        .brValid  (brValid),
        .brFunct3 (brFunct3),
        .brOff    (brOff)
    );

    // every legal non-branch instruction writes back, even to x0
    branchUnit #(.dataWidth(dataWidth)) i_branchUnit (
        .clk         (clk),
        .rstN        (rstN),
        .advance     (wb.valid),
        .brValid     (brValid),
        .brFunct3    (brFunct3),
        .brOff       (brOff),
        .flags       (flags),
        .branchValid (branchValid),
        .branchTaken (branchTaken),
        .pc          (pc)
    );

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #2 rstN = 1'b1;  // released just after an edge like every other input
    end

endmodule

// ==== test/execCoreTb.sv ====
`timescale 1ns/1ps

module execCoreTb;
    import isaPkg::*;
    import execPkg::*;

    localparam int maxRecords = 64;

    logic             clk;
    logic             rstN;
    logic             instValid;
    instWordT         inst;
    wbT               wb;
    logic             branchValid;
    logic             branchTaken;
    logic [63:0]      pc;
    logic             illegal;

    // each record is {inst, kind, rd, taken, value}
    logic [119:0]     stim [0:maxRecords-1];
    int               nRec;
    int               cycleCount;
    int               seed;
    logic [63:0]      modelRegs [0:31];
    logic [63:0]      modelPc;

    clockGen clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    execCore #(.dataWidth(64)) i_execCore (
        .clk         (clk),
        .rstN        (rstN),
        .instValid   (instValid),
        .inst        (inst),
        .wb          (wb),
        .branchValid (branchValid),
        .branchTaken (branchTaken),
        .pc          (pc),
        .illegal     (illegal)
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic reportValue(input string name, input logic [63:0] expVal,
                               input logic [63:0] gotVal);
        failRun($sformatf("ERROR %s exp %h got %h", name, expVal, gotVal));
    endtask

    // the result an OP or OPIMM word should produce on the current model state
    function automatic logic [63:0] refResult(input logic [31:0] w);
        logic [63:0] a;
        logic [63:0] b;
        a = modelRegs[w[19:15]];
        b = (w[6:0] == 7'h13) ? {{52{w[31]}}, w[31:20]} : modelRegs[w[24:20]];
        case (w[14:12])
            3'b111:  return a & b;
            3'b110:  return a | b;
            default: return (w[6:0] == 7'h33 && w[30]) ? a - b : a + b;
        endcase
    endfunction

    function automatic logic refTaken(input logic [31:0] w);
        logic [63:0] a;
        logic [63:0] b;
        a = modelRegs[w[19:15]];
        b = modelRegs[w[24:20]];
        case (w[14:12])
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [63:0] refOffset(input logic [31:0] w);
        return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // outputs of the instruction strobed two cycles ago, slot is -1 when idle
    task automatic checkStage2(input int slot);
        logic [31:0] w;
        logic [7:0]  kind;
        logic [63:0] expVal;
        logic        expTaken;
        kind = (slot < 0) ? 8'h02 : (stim[slot][87:80] & 8'h0f);
        w    = (slot < 0) ? 32'h0 : stim[slot][119:88];
        if (kind == 8'h00) begin
            expVal = refResult(w);
            assert (expVal == stim[slot][63:0])
                else failRun($sformatf("record %0d disagrees with the reference model", slot));
            assert (wb.valid == 1'b1) else reportValue("wb.valid", 64'h1, 64'(wb.valid));
            assert (wb.rd == stim[slot][76:72])
                else reportValue("wb.rd", 64'(stim[slot][76:72]), 64'(wb.rd));
            assert (wb.data == stim[slot][63:0])
                else reportValue("wb.data", stim[slot][63:0], wb.data);
            assert (branchValid == 1'b0) else reportValue("branchValid", 64'h0, 64'(branchValid));
            if (w[11:7] != 5'd0) begin
                modelRegs[w[11:7]] = expVal;
            end
            modelPc = modelPc + 64'd4;
        end else if (kind == 8'h01) begin
            expTaken = refTaken(w);
            assert (expTaken == stim[slot][64])
                else failRun($sformatf("record %0d disagrees with the reference model", slot));
            assert (branchValid == 1'b1) else reportValue("branchValid", 64'h1, 64'(branchValid));
            assert (wb.valid == 1'b0) else reportValue("wb.valid", 64'h0, 64'(wb.valid));
            assert (branchTaken == expTaken)
                else reportValue("branchTaken", 64'(expTaken), 64'(branchTaken));
            modelPc = modelPc + (expTaken ? refOffset(w) : 64'd4);
        end else begin
            // illegal words and idle cycles leave every stage-2 output quiet
            assert (wb.valid == 1'b0) else reportValue("wb.valid", 64'h0, 64'(wb.valid));
            assert (branchValid == 1'b0) else reportValue("branchValid", 64'h0, 64'(branchValid));
        end
        assert (branchTaken == 1'b0 || kind == 8'h01)
            else reportValue("branchTaken", 64'h0, 64'(branchTaken));
        assert (pc == modelPc) else reportValue("pc", modelPc, pc);
    endtask

    always @(posedge clk) begin
        if (rstN) begin
            cycleCount = cycleCount + 1;
            if (cycleCount > nRec * 4 + 50) begin
                failRun($sformatf("timeout: the run did not finish within %0d cycles",
                                  nRec * 4 + 50));
            end
        end
    end

    initial begin
        int  idx;
        int  slot1;
        int  slot2;
        int  newSlot;
        logic gapDone;
        instValid  = 1'b0;
        inst       = '0;
        cycleCount = 0;
        seed       = 32'hb140b926;
        modelPc    = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < maxRecords; i++) begin
            stim[i] = '0;
        end
        $readmemh("test/execStim.mem", stim);
        nRec = 0;
        while (nRec < maxRecords && stim[nRec] != '0) begin
            nRec++;
        end
        assert (nRec > 0) else failRun("the stimulus file holds no records");

        @(posedge rstN);
        @(posedge clk);
        #1;
        assert (wb.valid == 1'b0) else reportValue("wb.valid", 64'h0, 64'(wb.valid));
        assert (branchValid == 1'b0) else reportValue("branchValid", 64'h0, 64'(branchValid));
        assert (branchTaken == 1'b0) else reportValue("branchTaken", 64'h0, 64'(branchTaken));
        assert (illegal == 1'b0) else reportValue("illegal", 64'h0, 64'(illegal));
        assert (pc == 64'h0) else reportValue("pc", 64'h0, pc);
        #1;

        idx     = 0;
        slot1   = -1;
        slot2   = -1;
        gapDone = 1'b0;
        while (idx < nRec || slot1 >= 0 || slot2 >= 0) begin
            newSlot = -1;
            if (idx < nRec) begin
                // records flagged in the kind byte may be preceded by one idle cycle
                if (stim[idx][84] && !gapDone && ($random(seed) & 3) == 0) begin
                    gapDone = 1'b1;
                end else begin
                    newSlot = idx;
                    gapDone = 1'b0;
                    idx++;
                end
            end
            instValid = newSlot >= 0;
            inst      = (newSlot >= 0) ? stim[newSlot][119:88] : '0;
            @(posedge clk);
            #1;
            slot2 = slot1;
            slot1 = newSlot;
            assert (illegal == (slot1 >= 0 && stim[slot1][83:80] == 4'h2))
                else reportValue("illegal", 64'(slot1 >= 0 && stim[slot1][83:80] == 4'h2),
                                 64'(illegal));
            checkStage2(slot2);
            #1;
        end

        $display("test passed");
        $finish;
    end

endmodule

// ==== test/execStim.mem ====
// inst_kind_rd_taken_value, kind 00 write, 01 branch, 02 illegal, +10 allows an idle cycle before
// value is the expected wb.data for writes, taken is the expected branchTaken
00500093_00_01_00_0000000000000005
fff00113_00_02_00_ffffffffffffffff
7f00e193_00_03_00_00000000000007f5
00110233_10_04_00_0000000000000004
403202b3_00_05_00_fffffffffffff80f
0032f333_00_06_00_0000000000000005
002363b3_00_07_00_ffffffffffffffff
40208433_00_08_00_0000000000000006
00708013_10_00_00_000000000000000c
001004b3_00_09_00_0000000000000005
ff017513_00_0a_00_fffffffffffffff0
00908463_11_00_01_0000000000000000
00909463_01_00_00_0000000000000000
00114863_01_00_01_0000000000000000
00116863_01_00_00_0000000000000000
fe20dae3_01_00_01_0000000000000000
0020f463_01_00_00_0000000000000000
fe117ae3_11_00_01_0000000000000000
0020c463_01_00_00_0000000000000000
0020e463_01_00_01_0000000000000000
00255463_01_00_00_0000000000000000
0090d463_01_00_01_0000000000000000
ff000593_00_0b_00_fffffffffffffff0
fea58ae3_01_00_01_0000000000000000
0000a083_12_00_00_0000000000000000
0020c0b3_02_00_00_0000000000000000
00008633_10_0c_00_0000000000000005
401006b3_00_0d_00_fffffffffffffffb
00d68733_00_0e_00_fffffffffffffff6
002107b3_00_0f_00_fffffffffffffffe

// ==== execCore.f ====
design/isaPkg.sv
design/execPkg.sv
design/instDecoder.sv
design/regFile.sv
design/alu.sv
design/branchUnit.sv
design/execCore.sv
test/clockGen.sv
test/execCoreTb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f execCore.f --top-module execCoreTb

sim:
	verilator --binary --timing -f execCore.f --top-module execCoreTb --Mdir obj_dir -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
